// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = tb_acq_top
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: acq_controller.sv
// capture sequencer: frames the ADC, arms the buffer on trigger, runs correlation and report
`timescale 1ns/1ps

module acq_controller (
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 run,
    input  logic                 frame_done,
    input  logic                 triggered,
    input  logic                 buffer_full,
    input  logic                 xcorr_done,
    input  logic                 tx_ack,
    output logic                 adc_cs_n,
    output ctrl_pkg::input_sel_t input_sel,
    output logic                 xcorr_start,
    output logic                 tx_req,
    output logic                 busy
);
    import ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        trig_hit;      // last frame crossed the threshold
    logic        acked;         // UART has answered this report

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state       <= IDLE;
            trig_hit    <= 1'b0;
            acked       <= 1'b0;
            xcorr_start <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (frame_done)
            begin
                trig_hit <= triggered;
            end
            acked       <= (state == REPORT) && (acked || tx_ack);
            xcorr_start <= (state == TRIG_READY) && buffer_full;  // first XCORR cycle
        end
    end

    always_comb
    begin
        next_state = state;
        input_sel  = SEL_HOLD;
        case (state)
            IDLE:
            begin
                input_sel = SEL_ZERO;
                if (run)
                    next_state = PRE_WAIT;
            end
            PRE_WAIT:
            begin
                if (frame_done)
                begin
                    next_state = PRE_READY;
                    if (triggered)
                        input_sel = SEL_NEW;    // trigger sample becomes entry 0
                end
            end
            PRE_READY:  next_state = trig_hit ? TRIG_WAIT : PRE_WAIT;
            TRIG_WAIT:
            begin
                input_sel = SEL_NEW;
                if (frame_done)
                    next_state = TRIG_READY;
            end
            TRIG_READY: next_state = buffer_full ? XCORR : TRIG_WAIT;
            XCORR:
            begin
                if (xcorr_done)
                    next_state = REPORT;
            end
            REPORT:
            begin
                // both sides low again before leaving
                if (acked && !tx_ack)
                    next_state = IDLE;
            end
            default:    next_state = IDLE;
        endcase
    end

    assign adc_cs_n = !((state == PRE_WAIT) || (state == TRIG_WAIT));
    assign tx_req   = (state == REPORT) && !acked;
    assign busy     = (state != IDLE);

endmodule

// File: acq_pkg.sv
// signal path constants for the acoustic capture block: ADC framing, buffer, trigger, correlation
package acq_pkg;

    // ADC sample and serial frame
    localparam int SAMPLE_WIDTH   = 12;
    localparam int ADC_FRAME_BITS = 14;     // two leading zeros, then data msb first

    // capture buffer
    localparam int BUF_DEPTH = 8;
    localparam int PTR_WIDTH = 3;           // index into BUF_DEPTH entries

    // a sample at or above this level starts the capture
    localparam logic [SAMPLE_WIDTH-1:0] TRIG_THRESHOLD = 12'hC00;

    // cross-correlation against a +1/-1 code
    localparam int XCORR_LAGS = 4;
    localparam int PEAK_WIDTH = 16;         // signed, holds +/- 8 * 4095

    // bit i pairs with buffer entry i, 1 is +1 and 0 is -1
    localparam logic [BUF_DEPTH-1:0] XCORR_CODE = 8'b1011_0010;

endpackage

// File: acq_props.sv
// bound checks on the controller report handshake, chip select and correlation start
`timescale 1ns/1ps

module acq_props (
    input logic clk,
    input logic reset_b,
    input logic busy,
    input logic adc_cs_n,
    input logic xcorr_start,
    input logic tx_req,
    input logic tx_ack
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!reset_b)
        $rose(tx_ack) |-> tx_req)
        else $error("tx_ack rose while tx_req was low");

    req_held: assert property (@(posedge clk) disable iff (!reset_b)
        tx_req && !tx_ack |=> tx_req)
        else $error("tx_req dropped before tx_ack");

    ack_held: assert property (@(posedge clk) disable iff (!reset_b)
        tx_ack && tx_req |=> tx_ack)
        else $error("tx_ack dropped while tx_req still high");

    // report is left only once the UART has dropped ack
    idle_after_ack: assert property (@(posedge clk) disable iff (!reset_b)
        $fell(busy) |-> $past(!tx_ack))
        else $error("left report before tx_ack fell");

    cs_high_idle: assert property (@(posedge clk) disable iff (!reset_b)
        !busy |-> adc_cs_n)
        else $error("adc_cs_n low while not busy");

    start_pulse: assert property (@(posedge clk) disable iff (!reset_b)
        xcorr_start |=> !xcorr_start)
        else $error("xcorr_start longer than one cycle");

endmodule

// File: acq_top.sv
// acoustic capture top: ADC sampler, buffer, controller, correlator and report UART
`timescale 1ns/1ps

module acq_top (
    input  logic clk,
    input  logic reset_b,
    input  logic run,
    input  logic adc_data,
    output logic adc_cs_n,
    output logic uart_txd,
    output logic busy
);
    import acq_pkg::*;
    import ctrl_pkg::*;

    logic [SAMPLE_WIDTH-1:0]      sample;
    logic                         frame_done;
    logic                         triggered;
    input_sel_t                   input_sel;
    logic                         buffer_full;
    logic [PTR_WIDTH-1:0]         rd_index;
    logic [SAMPLE_WIDTH-1:0]      rd_sample;
    logic                         xcorr_start;
    logic                         xcorr_done;
    logic signed [PEAK_WIDTH-1:0] peak_value;
    logic [1:0]                   peak_lag;
    logic                         tx_req;
    logic                         tx_ack;

    adc_sampler u_sampler (
        .clk        (clk),
        .reset_b    (reset_b),
        .adc_cs_n   (adc_cs_n),
        .adc_data   (adc_data),
        .sample     (sample),
        .frame_done (frame_done),
        .triggered  (triggered)
    );

    sample_buffer u_buffer (
        .clk         (clk),
        .reset_b     (reset_b),
        .input_sel   (input_sel),
        .frame_done  (frame_done),
        .sample      (sample),
        .rd_index    (rd_index),
        .rd_sample   (rd_sample),
        .buffer_full (buffer_full)
    );

    acq_controller u_ctrl (
        .clk         (clk),
        .reset_b     (reset_b),
        .run         (run),
        .frame_done  (frame_done),
        .triggered   (triggered),
        .buffer_full (buffer_full),
        .xcorr_done  (xcorr_done),
        .tx_ack      (tx_ack),
        .adc_cs_n    (adc_cs_n),
        .input_sel   (input_sel),
        .xcorr_start (xcorr_start),
        .tx_req      (tx_req),
        .busy        (busy)
    );

    xcorr_engine u_xcorr (
        .clk         (clk),
        .reset_b     (reset_b),
        .xcorr_start (xcorr_start),
        .rd_sample   (rd_sample),
        .rd_index    (rd_index),
        .xcorr_done  (xcorr_done),
        .peak_value  (peak_value),
        .peak_lag    (peak_lag)
    );

    uart_report_tx u_uart (
        .clk        (clk),
        .reset_b    (reset_b),
        .tx_req     (tx_req),
        .peak_value (peak_value),
        .peak_lag   (peak_lag),
        .tx_ack     (tx_ack),
        .uart_txd   (uart_txd)
    );

endmodule

// File: adc_sampler.sv
// serial ADC receiver, collects each chip-select frame into a sample and flags the trigger
`timescale 1ns/1ps

module adc_sampler (
    input  logic                             clk,
    input  logic                             reset_b,
    input  logic                             adc_cs_n,
    input  logic                             adc_data,
    output logic [acq_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                             frame_done,
    output logic                             triggered
);
    import acq_pkg::*;

    logic [$clog2(ADC_FRAME_BITS)-1:0] bit_cnt;
    logic [SAMPLE_WIDTH-2:0]           shift_q;      // bits taken so far, top ones drop off
    logic [SAMPLE_WIDTH-1:0]           sample_next;
    logic [SAMPLE_WIDTH-1:0]           sample_q;

    // the 14th bit is on the line in this cycle
    assign frame_done  = !adc_cs_n && (bit_cnt == ADC_FRAME_BITS - 1);
    assign sample_next = {shift_q, adc_data};

    // new value is visible in the frame_done cycle so the buffer can write it
    assign sample    = frame_done ? sample_next : sample_q;
    assign triggered = frame_done && (sample_next >= TRIG_THRESHOLD);

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            bit_cnt <= '0;
        end
        else if (adc_cs_n || frame_done)
        begin
            bit_cnt <= '0;          // frame over or chip deselected
        end
        else
        begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!adc_cs_n)
        begin
            shift_q <= sample_next[SAMPLE_WIDTH-2:0];  // msb first
        end
        if (frame_done)
        begin
            sample_q <= sample_next;
        end
    end

endmodule

// File: ctrl_pkg.sv
// controller state and buffer select encodings plus UART report constants
package ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PRE_WAIT,       // clocking a frame before the trigger
        PRE_READY,
        TRIG_WAIT,      // clocking a frame into the buffer
        TRIG_READY,
        XCORR,
        REPORT          // req/ack with the UART
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SEL_ZERO = 2'b00,   // clear the buffer
        SEL_HOLD = 2'b01,   // keep contents
        SEL_NEW  = 2'b10    // take the new sample on frame_done
    } input_sel_t;

    // report line
    localparam int CLKS_PER_BIT    = 4;
    localparam int UART_FRAME_BITS = 10;    // start, 8 data, stop
    localparam int REPORT_BYTES    = 3;

endpackage

// File: sample_buffer.sv
// eight-entry capture buffer written under the controller's input select
`timescale 1ns/1ps

module sample_buffer (
    input  logic                             clk,
    input  logic                             reset_b,
    input  ctrl_pkg::input_sel_t             input_sel,
    input  logic                             frame_done,
    input  logic [acq_pkg::SAMPLE_WIDTH-1:0] sample,
    input  logic [acq_pkg::PTR_WIDTH-1:0]    rd_index,
    output logic [acq_pkg::SAMPLE_WIDTH-1:0] rd_sample,
    output logic                             buffer_full
);
    import acq_pkg::*;
    import ctrl_pkg::*;

    logic [SAMPLE_WIDTH-1:0] mem [BUF_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic                    full_q;
    logic                    wr_en;

    // writes stop once every entry holds a sample
    assign wr_en = (input_sel == SEL_NEW) && frame_done && !full_q;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            wr_ptr <= '0;
            full_q <= 1'b0;
        end
        else if (input_sel == SEL_ZERO)
        begin
            wr_ptr <= '0;           // cleared at any time, not only on frame_done
            full_q <= 1'b0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr == PTR_WIDTH'(BUF_DEPTH - 1))
            begin
                full_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= sample;
        end
    end

    assign rd_sample   = mem[rd_index];   // combinational read for the correlator
    assign buffer_full = full_q;

endmodule

// File: tb_acq_top.sv
// testbench for the acoustic capture top: ADC model, UART line decoder and correlation model
`timescale 1ns/1ps

module tb_acq_top;
    import acq_pkg::*;
    import ctrl_pkg::*;

    // frames pushed by the three runs below: 13 + 11 + 11
    localparam int RUNS         = 3;
    localparam int TOTAL_FRAMES = 35;
    localparam int FRAME_CYCLES = ADC_FRAME_BITS + 1;
    localparam int RUN_OVERHEAD = XCORR_LAGS * BUF_DEPTH + 2
                                  + REPORT_BYTES * UART_FRAME_BITS * CLKS_PER_BIT + 20;
    localparam int CYCLE_LIMIT  = 2 * (TOTAL_FRAMES * FRAME_CYCLES + RUNS * RUN_OVERHEAD) + 20;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic reset_b;
    logic run;
    logic adc_data = 1'b0;
    logic adc_cs_n;
    logic uart_txd;
    logic busy;

    logic [SAMPLE_WIDTH-1:0] stream [$];      // every sample the ADC will ever send
    logic [7:0]              rx_bytes [$];    // decoded report bytes
    logic [31:0]             lfsr = 32'h4943;
    int                      ref_win [BUF_DEPTH];
    int                      bit_pos = 0;
    int                      frame_idx = 0;   // frames fully clocked out
    int                      cycles = 0;
    int                      value_errors = 0;
    int                      state_errors = 0;
    int                      frame_errors = 0;

    acq_top dut0 (
        .clk      (clk),
        .reset_b  (reset_b),
        .run      (run),
        .adc_data (adc_data),
        .adc_cs_n (adc_cs_n),
        .uart_txd (uart_txd),
        .busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < nbits; k++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [SAMPLE_WIDTH-1:0] sample_at(input int idx);
        if (idx < stream.size())
            return stream[idx];
        return '0;
    endfunction

    // two leading zeros, then data msb first
    function automatic logic frame_bit(input logic [SAMPLE_WIDTH-1:0] s, input int k);
        logic [ADC_FRAME_BITS-1:0] f;
        f = {{(ADC_FRAME_BITS - SAMPLE_WIDTH){1'b0}}, s};
        return f[ADC_FRAME_BITS - 1 - k];
    endfunction

    task automatic push_samples(input int n, input int nbits, input logic [11:0] base);
        int k;
        for (k = 0; k < n; k++)
            stream.push_back(base | 12'(next_random(nbits)));
    endtask

    // +1/-1 code against the window, highest sum wins
    task automatic model_xcorr(output int peak, output int lag);
        int sum;
        int l;
        int i;
        peak = 0;
        lag  = 0;
        for (l = 0; l < XCORR_LAGS; l++)
        begin
            sum = 0;
            for (i = 0; i + l < BUF_DEPTH; i++)
            begin
                if (XCORR_CODE[i])
                    sum = sum + ref_win[i + l];
                else
                    sum = sum - ref_win[i + l];
            end
            if (l == 0 || sum > peak)   // earlier lag keeps a tie
            begin
                peak = sum;
                lag  = l;
            end
        end
    endtask

    // ADC model, the next frame bit goes out after each edge with chip select low
    always @(posedge clk)
    begin
        if (adc_cs_n)
        begin
            bit_pos  <= 0;
            adc_data <= 1'b0;           // first leading zero waits on the line
        end
        else if (bit_pos == ADC_FRAME_BITS - 1)
        begin
            bit_pos   <= 0;
            frame_idx <= frame_idx + 1;
            adc_data  <= 1'b0;
        end
        else
        begin
            bit_pos  <= bit_pos + 1;
            adc_data <= frame_bit(sample_at(frame_idx), bit_pos + 1);
        end
    end

    // line decoder, samples mid-bit on the falling edge
    initial
    begin : uart_decoder
        logic [7:0] data;
        int         k;
        wait (reset_b === 1'b1);
        forever
        begin
            @(negedge clk);
            if (uart_txd == 1'b0)
            begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (k = 0; k < 8; k++)
                begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[k] = uart_txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (uart_txd != 1'b1)
                begin
                    $display("UART stop bit missing after byte 0x%h", data);
                    frame_errors++;
                end
                rx_bytes.push_back(data);
            end
        end
    end

    task automatic check_idle(input int n);
        int k;
        for (k = 0; k < n; k++)
        begin
            @(negedge clk);
            assert (adc_cs_n == 1'b1)
            else
            begin
                $display("CHECK FAILED adc_cs_n expected 0x1 got 0x%h", adc_cs_n);
                state_errors++;
            end
            assert (uart_txd == 1'b1)
            else
            begin
                $display("CHECK FAILED uart_txd expected 0x1 got 0x%h", uart_txd);
                state_errors++;
            end
            assert (busy == 1'b0)
            else
            begin
                $display("CHECK FAILED busy expected 0x0 got 0x%h", busy);
                state_errors++;
            end
        end
    endtask

    task automatic capture_and_check(input int first, input bit lag2_case);
        int          t;
        int          k;
        int          exp_peak;
        int          exp_lag;
        int          rx_base;
        logic [15:0] pk;
        logic [7:0]  lag_byte;
        logic [15:0] got_pk;
        // trigger is the first frame at or above the level
        t = first;
        while (t < stream.size() && sample_at(t) < TRIG_THRESHOLD)
            t++;
        for (k = 0; k < BUF_DEPTH; k++)
            ref_win[k] = int'(sample_at(t + k));
        model_xcorr(exp_peak, exp_lag);
        pk      = 16'(exp_peak);
        rx_base = rx_bytes.size();

        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        do
            @(negedge clk);
        while (busy);

        assert (frame_idx == t + BUF_DEPTH)
        else
        begin
            $display("CHECK FAILED adc frames expected 0x%h got 0x%h", t + BUF_DEPTH, frame_idx);
            value_errors++;
        end
        assert (rx_bytes.size() == rx_base + REPORT_BYTES)
        else
        begin
            $display("report incomplete, %0d UART bytes instead of 3", rx_bytes.size() - rx_base);
            value_errors++;
        end
        if (rx_bytes.size() >= rx_base + REPORT_BYTES)
        begin
            lag_byte = rx_bytes[rx_base];
            got_pk   = {rx_bytes[rx_base + 1], rx_bytes[rx_base + 2]};
            assert (lag_byte == {6'd0, exp_lag[1:0]})
            else
            begin
                $display("CHECK FAILED peak_lag expected 0x%h got 0x%h", exp_lag[1:0], lag_byte);
                value_errors++;
            end
            assert (got_pk == pk)
            else
            begin
                $display("CHECK FAILED peak_value expected 0x%h got 0x%h", pk, got_pk);
                value_errors++;
            end
            assert (!lag2_case || lag_byte == 8'h02)
            else
            begin
                $display("CHECK FAILED peak_lag expected 0x2 got 0x%h", lag_byte);
                value_errors++;
            end
        end
    endtask

    initial
    begin
        int first;
        int k;
        reset_b = 1'b0;
        run     = 1'b0;
        repeat (2) @(posedge clk);
        reset_b <= 1'b1;
        check_idle(4);

        // quiet lead-in, one just below the level, trigger exactly at it
        first = stream.size();
        push_samples(4, 11, '0);
        stream.push_back(12'(TRIG_THRESHOLD - 1));
        stream.push_back(TRIG_THRESHOLD);
        push_samples(BUF_DEPTH - 1, 12, '0);
        capture_and_check(first, 1'b0);
        check_idle(3);

        // entries 2 to 7 follow the code so lag 2 lines up
        first = stream.size();
        push_samples(3, 11, '0);
        stream.push_back(12'hC80);
        stream.push_back(12'h100);
        for (k = 0; k < BUF_DEPTH - 2; k++)
            stream.push_back(XCORR_CODE[k] ? 12'hFFF : 12'h010);
        capture_and_check(first, 1'b1);
        check_idle(3);

        first = stream.size();
        push_samples(2, 11, '0);
        stream.push_back(12'(TRIG_THRESHOLD - 1));
        push_samples(1, 10, TRIG_THRESHOLD);        // random trigger above the level
        push_samples(BUF_DEPTH - 1, 12, '0);
        capture_and_check(first, 1'b0);
        check_idle(3);

        $display("errors: %0d value, %0d state, %0d uart framing",
                 value_errors, state_errors, frame_errors);
        if (value_errors + state_errors + frame_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", cycles);
        $display("Testbench failed");
        $finish;
    end

    bind acq_controller acq_props u_props (
        .clk         (clk),
        .reset_b     (reset_b),
        .busy        (busy),
        .adc_cs_n    (adc_cs_n),
        .xcorr_start (xcorr_start),
        .tx_req      (tx_req),
        .tx_ack      (tx_ack)
    );

endmodule

// File: uart_report_tx.sv
// UART transmitter for the three-byte peak report, answers the request with a four-phase ack
`timescale 1ns/1ps

module uart_report_tx (
    input  logic                                  clk,
    input  logic                                  reset_b,
    input  logic                                  tx_req,
    input  logic signed [acq_pkg::PEAK_WIDTH-1:0] peak_value,
    input  logic [1:0]                            peak_lag,
    output logic                                  tx_ack,
    output logic                                  uart_txd
);
    import acq_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_ACK} tx_state_t;

    tx_state_t                          state;
    logic [$clog2(CLKS_PER_BIT)-1:0]    clk_cnt;
    logic [$clog2(UART_FRAME_BITS)-1:0] bit_cnt;
    logic [$clog2(REPORT_BYTES)-1:0]    byte_cnt;
    logic [UART_FRAME_BITS-1:0]         frame;      // shifted out lsb first, fills with ones
    logic [PEAK_WIDTH-1:0]              rest;       // bytes still to go

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state    <= TX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            frame    <= '1;         // line idles high
            rest     <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (tx_req)
                    begin
                        frame    <= {1'b1, 6'd0, peak_lag, 1'b0};    // lag byte first
                        rest     <= peak_value;
                        byte_cnt <= '0;
                        clk_cnt  <= '0;
                        bit_cnt  <= '0;
                        state    <= TX_SEND;
                    end
                end
                TX_SEND:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CLKS_PER_BIT - 1)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        frame   <= {1'b1, frame[UART_FRAME_BITS-1:1]};
                        if (bit_cnt == UART_FRAME_BITS - 1)
                        begin
                            bit_cnt <= '0;
                            if (byte_cnt == REPORT_BYTES - 1)
                            begin
                                state <= TX_ACK;
                            end
                            else
                            begin
                                frame    <= {1'b1, rest[PEAK_WIDTH-1 -: 8], 1'b0}; // back to back
                                rest     <= {rest[PEAK_WIDTH-9:0], 8'h00};
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end
                end
                TX_ACK:
                begin
                    if (!tx_req)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign uart_txd = frame[0];
    assign tx_ack   = (state == TX_ACK);

endmodule

// File: verilog.f
acq_pkg.sv
ctrl_pkg.sv
adc_sampler.sv
sample_buffer.sv
acq_controller.sv
xcorr_engine.sv
uart_report_tx.sv
acq_top.sv
acq_props.sv
tb_acq_top.sv

// File: xcorr_engine.sv
// sequential cross-correlation of the buffer with the reference code over four lags, keeps the peak
`timescale 1ns/1ps

module xcorr_engine (
    input  logic                                  clk,
    input  logic                                  reset_b,
    input  logic                                  xcorr_start,
    input  logic [acq_pkg::SAMPLE_WIDTH-1:0]      rd_sample,
    output logic [acq_pkg::PTR_WIDTH-1:0]         rd_index,
    output logic                                  xcorr_done,
    output logic signed [acq_pkg::PEAK_WIDTH-1:0] peak_value,
    output logic [1:0]                            peak_lag
);
    import acq_pkg::*;

    logic                         running;
    logic [1:0]                   lag;
    logic [PTR_WIDTH-1:0]         idx;        // code bit in use
    logic [PTR_WIDTH:0]           pos;        // idx + lag, msb set means past the end
    logic signed [PEAK_WIDTH-1:0] acc;
    logic signed [PEAK_WIDTH-1:0] term;
    logic signed [PEAK_WIDTH-1:0] acc_next;

    assign pos      = {1'b0, idx} + {{(PTR_WIDTH - 1){1'b0}}, lag};
    assign rd_index = pos[PTR_WIDTH-1:0];
    assign term     = signed'({{(PEAK_WIDTH - SAMPLE_WIDTH){1'b0}}, rd_sample}); // unsigned sample

    always_comb
    begin
        if (pos[PTR_WIDTH])
            acc_next = acc;                 // no entry at this offset
        else if (XCORR_CODE[idx])
            acc_next = acc + term;
        else
            acc_next = acc - term;
    end

    // one entry per cycle, done follows the last lag by one cycle
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            running    <= 1'b0;
            lag        <= '0;
            idx        <= '0;
            acc        <= '0;
            xcorr_done <= 1'b0;
            peak_value <= '0;
            peak_lag   <= '0;
        end
        else
        begin
            xcorr_done <= 1'b0;
            if (xcorr_start)
            begin
                running <= 1'b1;
                lag     <= '0;
                idx     <= '0;
                acc     <= '0;
            end
            else if (running)
            begin
                if (idx == PTR_WIDTH'(BUF_DEPTH - 1))
                begin
                    // strict compare, lowest lag keeps a tie
                    if ((lag == 0) || (acc_next > peak_value))
                    begin
                        peak_value <= acc_next;
                        peak_lag   <= lag;
                    end
                    acc <= '0;
                    idx <= '0;
                    lag <= lag + 1'b1;
                    if (lag == 2'(XCORR_LAGS - 1))
                    begin
                        running    <= 1'b0;
                        xcorr_done <= 1'b1;
                    end
                end
                else
                begin
                    acc <= acc_next;
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule
